/* src/fdsu_defs.svh */
`ifndef FDSU_DEFS_SVH
`define FDSU_DEFS_SVH

// Signed internal exponent, wide enough for the ex1 difference plus bias
`define FDSU_EXPNT_W 13

// Double precision exponent bias
`define FDSU_BIAS 1023

// All-ones biased exponent for infinity and NaN
`define FDSU_EXPNT_MAX 2047

// Fraction field width
`define FDSU_FRAC_W 52

`endif

/* src/fdsu_pkg.sv */
package fdsu_pkg;

  `include "fdsu_defs.svh"

  // One operand word, read whole or split into IEEE-754 fields
  typedef union packed {
    logic [63:0] raw;
    struct packed {
      logic                    sign;
      logic [10:0]             expnt;
      logic [`FDSU_FRAC_W-1:0] frac;
    } fields;
  } fdsu_double_t;

  // Per-operand classification
  // Zero exponent field counts as zero, denormals are not kept
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_norm;
    logic sign;
  } fdsu_class_t;

endpackage

/* src/fdsu_ctrl.sv */
`timescale 1ns/10ps

module fdsu_ctrl
  import fdsu_pkg::*;
(
  input  logic         expnt_rst_clk,
  input  logic         rst_n,
  input  logic         start,
  input  fdsu_double_t op0,
  input  fdsu_double_t op1,
  output fdsu_double_t op0_q,
  output fdsu_double_t op1_q,
  output logic         ex1_pipedown,
  output logic         ex2_pipedown,
  output logic         ex3_pipedown,
  output logic         busy,
  output logic         done
);

  // One bit per stage, ex1 in bit 0 up to ex4 in bit 3
  logic [3:0] stage_q;
  logic       accept;

  assign busy   = |stage_q;
  assign accept = start && !busy;

  always_ff @(posedge expnt_rst_clk or negedge rst_n)
  begin
    if (!rst_n)
      stage_q <= 4'b0000;
    else
      stage_q <= {stage_q[2:0], accept};
  end

  // Operands are held for the whole operation, later stages still read the fractions
  always_ff @(posedge expnt_rst_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      op0_q <= '0;
      op1_q <= '0;
    end
    else if (accept)
    begin
      op0_q <= op0;
      op1_q <= op1;
    end
  end

  assign ex1_pipedown = stage_q[0];
  assign ex2_pipedown = stage_q[1];
  assign ex3_pipedown = stage_q[2];
  // ex4 holds the finished result
  assign done         = stage_q[3];

  // Only one operation in flight, so the shared exponent register sees one load per cycle
  ap_pipedown_excl: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n)
    $onehot0({ex1_pipedown, ex2_pipedown, ex3_pipedown})
  ) else $error("fdsu_ctrl: overlapping pipedowns");

endmodule

/* src/fdsu_expnt.sv */
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_expnt
  import fdsu_pkg::*;
(
  input  fdsu_double_t             op0_q,
  input  fdsu_double_t             op1_q,
  input  logic [`FDSU_EXPNT_W-1:0] expnt_rst,
  input  logic                     of_q,
  input  logic                     uf_q,
  output logic [`FDSU_EXPNT_W-1:0] ex1_expnt_adder_op0,
  output logic [`FDSU_EXPNT_W-1:0] ex2_srt_expnt_rst,
  output logic                     ex2_of,
  output logic                     ex2_uf,
  output logic [`FDSU_EXPNT_W-1:0] ex3_expnt_adjust_result
);

  logic [`FDSU_EXPNT_W-1:0] op0_expnt_ext;
  logic [`FDSU_EXPNT_W-1:0] op1_expnt_ext;
  logic                     frac_lt;
  logic                     ex2_neg;

  // Zero-extend the biased field exponents
  assign op0_expnt_ext = {{(`FDSU_EXPNT_W-11){1'b0}}, op0_q.fields.expnt};
  assign op1_expnt_ext = {{(`FDSU_EXPNT_W-11){1'b0}}, op1_q.fields.expnt};

  // ex1, difference of biased exponents, rebiased
  assign ex1_expnt_adder_op0 = op0_expnt_ext - op1_expnt_ext
                             + `FDSU_EXPNT_W'(`FDSU_BIAS);

  // ex2, quotient mantissa below one when the dividend fraction is smaller
  assign frac_lt           = op0_q.fields.frac < op1_q.fields.frac;
  assign ex2_srt_expnt_rst = expnt_rst - {{(`FDSU_EXPNT_W-1){1'b0}}, frac_lt};

  // Range checks on the adjusted value as a signed number
  assign ex2_neg = ex2_srt_expnt_rst[`FDSU_EXPNT_W-1];
  assign ex2_of  = !ex2_neg && (ex2_srt_expnt_rst >= `FDSU_EXPNT_W'(`FDSU_EXPNT_MAX));
  assign ex2_uf  = ex2_neg || (ex2_srt_expnt_rst == '0);

  // ex3, overflow saturates to inf exponent, underflow flushes to zero
  always_comb
  begin
    if (of_q)
      ex3_expnt_adjust_result = `FDSU_EXPNT_W'(`FDSU_EXPNT_MAX);
    else if (uf_q)
      ex3_expnt_adjust_result = '0;
    else
      ex3_expnt_adjust_result = expnt_rst;
  end

endmodule

/* src/fdsu_special.sv */
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_special
  import fdsu_pkg::*;
(
  input  fdsu_double_t op0_q,
  input  fdsu_double_t op1_q,
  output logic         ex1_nv,
  output logic         ex1_dz,
  output logic         ex1_result_inf,
  output logic         ex1_result_zero,
  output logic         ex1_result_qnan,
  output logic         ex1_result_sign
);

  fdsu_class_t cls0;
  fdsu_class_t cls1;
  logic        op0_finite;
  logic        op1_finite;

  function automatic fdsu_class_t classify(input fdsu_double_t op);
    fdsu_class_t c;
    logic        expnt_max;
    logic        frac_nz;
    expnt_max = (op.fields.expnt == 11'(`FDSU_EXPNT_MAX));
    frac_nz   = |op.fields.frac;
    c.is_zero = (op.fields.expnt == '0);
    c.is_inf  = expnt_max && !frac_nz;
    c.is_nan  = expnt_max && frac_nz;
    // Quiet bit is the fraction msb
    c.is_snan = expnt_max && frac_nz && !op.fields.frac[`FDSU_FRAC_W-1];
    c.is_norm = !c.is_zero && !expnt_max;
    c.sign    = op.fields.sign;
    return c;
  endfunction

  assign cls0 = classify(op0_q);
  assign cls1 = classify(op1_q);

  assign op0_finite = cls0.is_zero || cls0.is_norm;
  assign op1_finite = cls1.is_zero || cls1.is_norm;

  // Invalid for sNaN, 0/0 and inf/inf
  assign ex1_nv = cls0.is_snan || cls1.is_snan
               || (cls0.is_zero && cls1.is_zero)
               || (cls0.is_inf && cls1.is_inf);

  assign ex1_result_qnan = ex1_nv || cls0.is_nan || cls1.is_nan;

  // Finite non-zero over zero
  assign ex1_dz = cls1.is_zero && cls0.is_norm;

  assign ex1_result_inf = (cls0.is_inf && op1_finite) || ex1_dz;

  assign ex1_result_zero = (cls0.is_zero && !cls1.is_zero && !cls1.is_nan)
                        || (cls1.is_inf && op0_finite);

  // Default NaN is positive
  assign ex1_result_sign = (cls0.sign ^ cls1.sign) && !ex1_result_qnan;

  // The three result kinds come from separate operand cases and must not collide
  always_comb
  begin
    assert ($onehot0({ex1_result_qnan, ex1_result_inf, ex1_result_zero}))
      else $error("fdsu_special: qnan/inf/zero raised together");
  end

endmodule

/* src/fdsu_double_dp.sv */
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_double_dp (
  input  logic                     expnt_rst_clk,
  input  logic                     rst_n,
  input  logic                     ex1_pipedown,
  input  logic                     ex2_pipedown,
  input  logic                     ex3_pipedown,
  input  logic                     ex1_nv,
  input  logic                     ex1_dz,
  input  logic                     ex1_result_inf,
  input  logic                     ex1_result_zero,
  input  logic                     ex1_result_qnan,
  input  logic                     ex1_result_sign,
  input  logic [`FDSU_EXPNT_W-1:0] ex1_expnt_adder_op0,
  input  logic [`FDSU_EXPNT_W-1:0] ex2_srt_expnt_rst,
  input  logic                     ex2_of,
  input  logic                     ex2_uf,
  input  logic [`FDSU_EXPNT_W-1:0] ex3_expnt_adjust_result,
  output logic [`FDSU_EXPNT_W-1:0] expnt_rst,
  output logic                     of_q,
  output logic                     uf_q,
  output logic                     result_sign,
  output logic [10:0]              result_expnt,
  output logic                     nv,
  output logic                     dz,
  output logic                     of,
  output logic                     uf,
  output logic                     result_inf,
  output logic                     result_zero,
  output logic                     result_qnan
);

  logic [`FDSU_EXPNT_W-1:0] expnt_q;
  logic                     nv_q;
  logic                     dz_q;
  logic                     inf_q;
  logic                     zero_q;
  logic                     qnan_q;
  logic                     sign_q;
  logic                     no_special;

  // Single exponent register, one value per stage
  always_ff @(posedge expnt_rst_clk or negedge rst_n)
  begin
    if (!rst_n)
      expnt_q <= '0;
    else if (ex1_pipedown)
      expnt_q <= ex1_expnt_adder_op0;
    else if (ex2_pipedown)
      expnt_q <= ex2_srt_expnt_rst;
    else if (ex3_pipedown)
      expnt_q <= ex3_expnt_adjust_result;
  end

  assign expnt_rst  = expnt_q;
  assign no_special = !(qnan_q || inf_q || zero_q);

  // Special flags from ex1, range flags folded in at ex2
  always_ff @(posedge expnt_rst_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      nv_q   <= 1'b0;
      dz_q   <= 1'b0;
      inf_q  <= 1'b0;
      zero_q <= 1'b0;
      qnan_q <= 1'b0;
      sign_q <= 1'b0;
      of_q   <= 1'b0;
      uf_q   <= 1'b0;
    end
    else if (ex1_pipedown)
    begin
      nv_q   <= ex1_nv;
      dz_q   <= ex1_dz;
      inf_q  <= ex1_result_inf;
      zero_q <= ex1_result_zero;
      qnan_q <= ex1_result_qnan;
      sign_q <= ex1_result_sign;
    end
    else if (ex2_pipedown)
    begin
      inf_q  <= inf_q || (ex2_of && no_special);
      zero_q <= zero_q || (ex2_uf && no_special);
      of_q   <= ex2_of && no_special;
      uf_q   <= ex2_uf && no_special;
    end
  end

  always_comb
  begin
    if (qnan_q || inf_q)
      result_expnt = 11'(`FDSU_EXPNT_MAX);
    else if (zero_q)
      result_expnt = '0;
    else
      result_expnt = expnt_q[10:0];
  end

  assign result_sign = sign_q;
  assign nv          = nv_q;
  assign dz          = dz_q;
  assign of          = of_q;
  assign uf          = uf_q;
  assign result_inf  = inf_q;
  assign result_zero = zero_q;
  assign result_qnan = qnan_q;

  // The ex3 clamp in the exponent path must leave an inf exponent in the register
  ap_of_clamp: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n)
    ex3_pipedown && of_q |=> result_inf
      && (expnt_rst == `FDSU_EXPNT_W'(`FDSU_EXPNT_MAX))
      && (result_expnt == 11'(`FDSU_EXPNT_MAX))
  ) else $error("fdsu_double_dp: overflow without inf exponent");

endmodule

/* src/fdsu_top.sv */
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_top
  import fdsu_pkg::*;
(
  input  logic         expnt_rst_clk,
  input  logic         rst_n,
  input  logic         start,
  input  fdsu_double_t op0,
  input  fdsu_double_t op1,
  output logic         busy,
  output logic         done,
  output logic         result_sign,
  output logic [10:0]  result_expnt,
  output logic         nv,
  output logic         dz,
  output logic         of,
  output logic         uf,
  output logic         result_inf,
  output logic         result_zero,
  output logic         result_qnan
);

  fdsu_double_t             op0_q;
  fdsu_double_t             op1_q;
  logic                     ex1_pipedown;
  logic                     ex2_pipedown;
  logic                     ex3_pipedown;
  logic                     ex1_nv;
  logic                     ex1_dz;
  logic                     ex1_result_inf;
  logic                     ex1_result_zero;
  logic                     ex1_result_qnan;
  logic                     ex1_result_sign;
  logic [`FDSU_EXPNT_W-1:0] expnt_rst;
  logic                     of_q;
  logic                     uf_q;
  logic [`FDSU_EXPNT_W-1:0] ex1_expnt_adder_op0;
  logic [`FDSU_EXPNT_W-1:0] ex2_srt_expnt_rst;
  logic                     ex2_of;
  logic                     ex2_uf;
  logic [`FDSU_EXPNT_W-1:0] ex3_expnt_adjust_result;

  fdsu_ctrl i_fdsu_ctrl (
    .expnt_rst_clk (expnt_rst_clk),
    .rst_n         (rst_n),
    .start         (start),
    .op0           (op0),
    .op1           (op1),
    .op0_q         (op0_q),
    .op1_q         (op1_q),
    .ex1_pipedown  (ex1_pipedown),
    .ex2_pipedown  (ex2_pipedown),
    .ex3_pipedown  (ex3_pipedown),
    .busy          (busy),
    .done          (done)
  );

  fdsu_expnt i_fdsu_expnt (
    .op0_q                   (op0_q),
    .op1_q                   (op1_q),
    .expnt_rst               (expnt_rst),
    .of_q                    (of_q),
    .uf_q                    (uf_q),
    .ex1_expnt_adder_op0     (ex1_expnt_adder_op0),
    .ex2_srt_expnt_rst       (ex2_srt_expnt_rst),
    .ex2_of                  (ex2_of),
    .ex2_uf                  (ex2_uf),
    .ex3_expnt_adjust_result (ex3_expnt_adjust_result)
  );

  fdsu_special i_fdsu_special (
    .op0_q           (op0_q),
    .op1_q           (op1_q),
    .ex1_nv          (ex1_nv),
    .ex1_dz          (ex1_dz),
    .ex1_result_inf  (ex1_result_inf),
    .ex1_result_zero (ex1_result_zero),
    .ex1_result_qnan (ex1_result_qnan),
    .ex1_result_sign (ex1_result_sign)
  );

  fdsu_double_dp i_fdsu_double_dp (
    .expnt_rst_clk           (expnt_rst_clk),
    .rst_n                   (rst_n),
    .ex1_pipedown            (ex1_pipedown),
    .ex2_pipedown            (ex2_pipedown),
    .ex3_pipedown            (ex3_pipedown),
    .ex1_nv                  (ex1_nv),
    .ex1_dz                  (ex1_dz),
    .ex1_result_inf          (ex1_result_inf),
    .ex1_result_zero         (ex1_result_zero),
    .ex1_result_qnan         (ex1_result_qnan),
    .ex1_result_sign         (ex1_result_sign),
    .ex1_expnt_adder_op0     (ex1_expnt_adder_op0),
    .ex2_srt_expnt_rst       (ex2_srt_expnt_rst),
    .ex2_of                  (ex2_of),
    .ex2_uf                  (ex2_uf),
    .ex3_expnt_adjust_result (ex3_expnt_adjust_result),
    .expnt_rst               (expnt_rst),
    .of_q                    (of_q),
    .uf_q                    (uf_q),
    .result_sign             (result_sign),
    .result_expnt            (result_expnt),
    .nv                      (nv),
    .dz                      (dz),
    .of                      (of),
    .uf                      (uf),
    .result_inf              (result_inf),
    .result_zero             (result_zero),
    .result_qnan             (result_qnan)
  );

endmodule

/* test/fdsu_tb.sv */
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_tb
  import fdsu_pkg::*;
;

  localparam int DONE_TIMEOUT = 20;
  localparam int DONE_EDGES   = 3;

  logic         expnt_rst_clk;
  logic         rst_n;
  logic         start;
  fdsu_double_t op0;
  fdsu_double_t op1;
  logic         busy;
  logic         done;
  logic         result_sign;
  logic [10:0]  result_expnt;
  logic         nv;
  logic         dz;
  logic         of;
  logic         uf;
  logic         result_inf;
  logic         result_zero;
  logic         result_qnan;

  // Expected results of the operation in flight
  logic [10:0]  exp_expnt;
  logic         exp_sign;
  logic [6:0]   exp_flags;
  logic [6:0]   flags;

  int error_count;
  int test_count;
  int failed_tests;
  int errors_at_open;

  fdsu_top i_fdsu_top (
    .expnt_rst_clk (expnt_rst_clk),
    .rst_n         (rst_n),
    .start         (start),
    .op0           (op0),
    .op1           (op1),
    .busy          (busy),
    .done          (done),
    .result_sign   (result_sign),
    .result_expnt  (result_expnt),
    .nv            (nv),
    .dz            (dz),
    .of            (of),
    .uf            (uf),
    .result_inf    (result_inf),
    .result_zero   (result_zero),
    .result_qnan   (result_qnan)
  );

  assign flags = {nv, dz, of, uf, result_inf, result_zero, result_qnan};

  initial
  begin
    expnt_rst_clk = 1'b0;
    forever #20 expnt_rst_clk = ~expnt_rst_clk;
  end

  // Results are compared in the cycle where done is high
  a_expnt: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n) done |-> result_expnt == exp_expnt
  ) else
  begin
    error_count++;
    $display("mismatch at %0t: result_expnt got %0d expected %0d",
             $time, result_expnt, exp_expnt);
  end

  a_sign: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n) done |-> result_sign == exp_sign
  ) else
  begin
    error_count++;
    $display("mismatch at %0t: result_sign got %0b expected %0b",
             $time, result_sign, exp_sign);
  end

  a_flags: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n) done |-> flags == exp_flags
  ) else
  begin
    error_count++;
    $display("mismatch at %0t: flags {nv,dz,of,uf,inf,zero,qnan} got %b expected %b",
             $time, flags, exp_flags);
  end

  // Idle means no pipedown, so every output keeps its value
  a_hold: assert property (
    @(posedge expnt_rst_clk) disable iff (!rst_n)
    !busy |=> $stable(result_expnt) && $stable(result_sign) && $stable(flags)
  ) else
  begin
    error_count++;
    $display("outputs changed at %0t while the divider was idle", $time);
  end

  task automatic compute_expected(input logic [63:0] a, input logic [63:0] b);
    int e0;
    int e1;
    int q;
    bit z0, z1, i0, i1, n0, n1, s0, s1;
    bit enan, edz, einf, ezero, eqnan, eof, euf;
    e0 = int'(a[62:52]);
    e1 = int'(b[62:52]);
    z0 = (e0 == 0);
    z1 = (e1 == 0);
    i0 = (e0 == `FDSU_EXPNT_MAX) && (a[51:0] == 52'd0);
    i1 = (e1 == `FDSU_EXPNT_MAX) && (b[51:0] == 52'd0);
    n0 = (e0 == `FDSU_EXPNT_MAX) && !i0;
    n1 = (e1 == `FDSU_EXPNT_MAX) && !i1;
    s0 = n0 && !a[51];
    s1 = n1 && !b[51];
    enan  = s0 || s1 || (z0 && z1) || (i0 && i1);
    eqnan = enan || n0 || n1;
    edz   = z1 && !z0 && (e0 != `FDSU_EXPNT_MAX);
    einf  = (i0 && e1 != `FDSU_EXPNT_MAX) || edz;
    ezero = (z0 && !z1 && !n1) || (i1 && e0 != `FDSU_EXPNT_MAX);
    q = e0 - e1 + `FDSU_BIAS;
    if (a[51:0] < b[51:0])
      q = q - 1;
    eof = !(eqnan || einf || ezero) && (q >= `FDSU_EXPNT_MAX);
    euf = !(eqnan || einf || ezero) && (q <= 0);
    if (eqnan || einf || eof)
      exp_expnt = 11'(`FDSU_EXPNT_MAX);
    else if (ezero || euf)
      exp_expnt = 11'd0;
    else
      exp_expnt = q[10:0];
    exp_sign  = (a[63] ^ b[63]) && !eqnan;
    exp_flags = {enan, edz, eof, euf, einf || eof, ezero || euf, eqnan};
  endtask

  function automatic logic [63:0] make_normal(input int lo, input int hi);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [10:0] e;
    r0 = $urandom();
    r1 = $urandom();
    e  = 11'(lo + int'($urandom() % 32'(hi - lo + 1)));
    return {r1[31], e, r1[19:0], r0};
  endfunction

  // Runs one operation; a second start is raised at cycle poke while busy
  task automatic run_op(input logic [63:0] a, input logic [63:0] b, input int poke);
    int cycles;
    compute_expected(a, b);
    op0.raw = a;
    op1.raw = b;
    start   = 1'b1;
    @(posedge expnt_rst_clk);
    #2;
    start  = 1'b0;
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_TIMEOUT)
    begin
      @(posedge expnt_rst_clk);
      #2;
      cycles++;
      start = (cycles == poke);
      if (cycles == poke)
      begin
        op0.raw = make_normal(1, 2046);
        op1.raw = make_normal(1, 2046);
      end
    end
    start = 1'b0;
    if (done !== 1'b1)
    begin
      $display("timeout: done not seen within %0d cycles at %0t", DONE_TIMEOUT, $time);
      $display("Test FAILED");
      $finish;
    end
    else
    begin
      assert (cycles == DONE_EDGES) else
      begin
        error_count++;
        $display("mismatch at %0t: done latency got %0d expected %0d",
                 $time, cycles, DONE_EDGES);
      end
      @(posedge expnt_rst_clk);
      #2;
      assert (done == 1'b0 && busy == 1'b0) else
      begin
        error_count++;
        $display("done or busy still high one cycle after done at %0t", $time);
      end
    end
  endtask

  task automatic open_test();
    errors_at_open = error_count;
  endtask

  task automatic close_test(input string name);
    test_count++;
    if (error_count == errors_at_open)
      $display("test %s: passed", name);
    else
    begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, error_count - errors_at_open);
    end
  endtask

  initial
  begin
    rst_n        = 1'b0;
    start        = 1'b0;
    op0          = '0;
    op1          = '0;
    exp_expnt    = '0;
    exp_sign     = 1'b0;
    exp_flags    = '0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    void'($urandom(32'h8081_6d36));
    repeat (8) @(posedge expnt_rst_clk);
    #2;
    rst_n = 1'b1;

    open_test();
    assert (busy == 1'b0 && done == 1'b0 && flags == 7'd0 && result_sign == 1'b0) else
    begin
      error_count++;
      $display("status or flags not clear after reset at %0t", $time);
    end
    run_op(64'h3FF8_0000_0000_0000, 64'h4000_0000_0000_0000, 0);
    close_test("reset_and_latency");

    open_test();
    repeat (40)
      run_op(make_normal(600, 1446), make_normal(600, 1446), 0);
    close_test("random_normal");

    open_test();
    run_op(64'h7FE0_0000_0000_0000, 64'h0010_0000_0000_0000, 0);
    run_op(64'h7FEF_0000_0000_0000, 64'h3FE0_0000_0000_0000, 0);
    run_op(64'h7FE0_0000_0000_0000, 64'h3FEF_0000_0000_0000, 0);
    run_op(64'hFFE0_0000_0000_0000, 64'h3FE0_0000_0000_0000, 0);
    run_op(64'h0010_0000_0000_0000, 64'h7FE0_0000_0000_0000, 0);
    run_op(64'h0010_0000_0000_0000, 64'h4000_0000_0000_0000, 0);
    run_op(64'h0010_0000_0000_0000, 64'h3FFF_0000_0000_0000, 0);
    run_op(64'h8010_0000_0000_0000, 64'h3FF0_0000_0000_0000, 0);
    close_test("overflow_underflow");

    open_test();
    run_op(64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
    run_op(64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000, 0);
    run_op(64'h7FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000, 0);
    run_op(64'h3FF0_0000_0000_0000, 64'hFFF4_0000_0000_0000, 0);
    run_op(64'h7FF8_0000_0000_0000, 64'h3FF0_0000_0000_0000, 0);
    run_op(64'h7FF8_0000_0000_0000, 64'h0000_0000_0000_0000, 0);
    run_op(64'hC008_0000_0000_0000, 64'h0000_0000_0000_0000, 0);
    run_op(64'hFFF0_0000_0000_0000, 64'h4010_0000_0000_0000, 0);
    run_op(64'h7FF0_0000_0000_0000, 64'h0000_0000_0000_0000, 0);
    run_op(64'h8000_0000_0000_0000, 64'h4010_0000_0000_0000, 0);
    // Denormal dividend counts as zero
    run_op(64'h0000_0000_0000_0001, 64'h4010_0000_0000_0000, 0);
    run_op(64'h4010_0000_0000_0000, 64'hFFF0_0000_0000_0000, 0);
    run_op(64'h0000_0000_0000_0000, 64'h7FF0_0000_0000_0000, 0);
    close_test("special_operands");

    open_test();
    run_op(make_normal(600, 1446), make_normal(600, 1446), 1);
    run_op(make_normal(600, 1446), make_normal(600, 1446), 2);
    // Long idle stretch for the output hold assertion
    repeat (6) @(posedge expnt_rst_clk);
    #2;
    run_op(64'h7FF0_0000_0000_0000, 64'h3FF0_0000_0000_0000, 0);
    repeat (4) @(posedge expnt_rst_clk);
    #2;
    close_test("busy_ignore_and_hold");

    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+src
src/fdsu_pkg.sv
src/fdsu_ctrl.sv
src/fdsu_expnt.sv
src/fdsu_special.sv
src/fdsu_double_dp.sv
src/fdsu_top.sv
test/fdsu_tb.sv

/* Makefile */
# Verilator simulation of the FDSU exponent path

VERILATOR ?= verilator
TOP       ?= fdsu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
